/* mer_test.f */
+incdir+source
source/mer_pkg.sv
source/symbol_mapper.sv
source/isi_channel.sv
source/mer_accumulator.sv
source/mer_test_top.sv
bench/mer_asserts.sv
bench/mer_tb.sv

/* Makefile */
# Verilator flow for the MER test channel

.PHONY: all lint clean

all: obj_dir/mer_sim
	./obj_dir/mer_sim | tee sim.log
	grep -q ">>> PASS" sim.log

obj_dir/mer_sim: mer_test.f source/*.sv source/*.svh bench/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  -f mer_test.f --top-module mer_tb -o mer_sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
	  -f mer_test.f --top-module mer_tb

clean:
	rm -rf obj_dir sim.log

/* bench/mer_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mer_macros.svh"

module mer_tb
  import mer_pkg::*;
();

  localparam int     BLOCK = `MER_BLOCK_LEN;
  localparam int     GAIN  = `MER_CHANNEL_GAIN;
  localparam longint QTR   = 1 << (`MER_DATA_WIDTH - 3);  // quarter of full scale
  localparam longint HALF  = 1 << (`MER_DATA_WIDTH - 2);  // half of full scale

  logic        clk;
  logic        reset;
  logic        sym_valid;
  symbol_e     sym;
  logic        sym_ready;
  logic        report_valid;
  mer_report_t report;
  logic        report_ready;

  integer      seed;
  bit          saw_full;               // sym_ready seen low behind a held report
  symbol_e     sym_q[$];               // symbols for the current phase
  int          gap_q[$];               // idle cycles before each symbol
  int          saved_gaps[$];
  mer_report_t exp_q[$];               // model reports not yet seen
  mer_report_t got_q[$];               // reports seen in this phase
  mer_report_t first_pass[$];

  longint      tap1;                   // model centre tap
  longint      tap2;                   // model oldest tap
  int          m_count;
  int          m_errors;
  longint      m_signal;
  longint      m_error;

  mer_test_top uut (
    .clk          (clk),
    .reset        (reset),
    .sym_valid    (sym_valid),
    .sym          (sym),
    .sym_ready    (sym_ready),
    .report_valid (report_valid),
    .report       (report),
    .report_ready (report_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;             // 4 ns period
  end

  always @(negedge clk)
  begin
    if (report_valid && !report_ready && !sym_ready)
      saw_full = 1'b1;                 // whole pipeline backed up behind the stall
  end

  //************************************************************
  // error reporting
  //************************************************************

  task automatic value_error(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "value check failed");
  endtask

  task automatic hard_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic compare_report(input mer_report_t got, input mer_report_t exp, input int idx);
    if (got.symbol_errors !== exp.symbol_errors)
      value_error($sformatf("report %0d symbol_errors got %0d expected %0d",
                            idx, got.symbol_errors, exp.symbol_errors));
    if (got.signal_energy !== exp.signal_energy)
      value_error($sformatf("report %0d signal_energy got %0d expected %0d",
                            idx, got.signal_energy, exp.signal_energy));
    if (got.error_energy !== exp.error_energy)
      value_error($sformatf("report %0d error_energy got %0d expected %0d",
                            idx, got.error_energy, exp.error_energy));
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp)
      value_error($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  //************************************************************
  // reference model
  //************************************************************

  function automatic longint nominal(input symbol_e s);
    case (s)
      SYM_M3:  return -3 * QTR;
      SYM_M1:  return -QTR;
      SYM_P1:  return QTR;
      default: return 3 * QTR;
    endcase
  endfunction

  // nearest level after the gain, ties toward the upper level
  function automatic symbol_e nearest(input longint x);
    longint th;
    th = HALF >>> GAIN;
    if (x >= th)
      return SYM_P3;
    else if (x >= 0)
      return SYM_P1;
    else if (x >= -th)
      return SYM_M1;
    return SYM_M3;
  endfunction

  task automatic model_symbol(input symbol_e s);
    longint      t0;
    longint      isi;
    longint      dec;
    longint      errless;
    longint      ideal;
    mer_report_t r;
    t0      = nominal(s);
    isi     = ((t0 + tap2) * `MER_ISI_POWER) >>> (`MER_DATA_WIDTH - 1);  // back to Q1.17
    errless = tap1 >>> GAIN;
    dec     = (isi >>> GAIN) + errless;
    ideal   = nominal(nearest(dec)) >>> GAIN;
    if (nearest(dec) != nearest(errless))
      m_errors++;
    m_signal += ideal * ideal;
    m_error  += (dec - ideal) * (dec - ideal);
    tap2 = tap1;
    tap1 = t0;
    m_count++;
    if (m_count == BLOCK)
    begin
      r.symbol_errors = 16'(m_errors);
      r.signal_energy = `MER_ACC_WIDTH'(m_signal);
      r.error_energy  = `MER_ACC_WIDTH'(m_error);
      exp_q.push_back(r);
      m_count  = 0;
      m_errors = 0;
      m_signal = 0;
      m_error  = 0;
    end
  endtask

  //************************************************************
  // stimulus and collection
  //************************************************************

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset        = 1'b0;
    sym_valid    = 1'b0;
    report_ready = 1'b0;
    tap1 = 0;                          // model taps start empty like the DUT
    tap2 = 0;
    m_count  = 0;
    m_errors = 0;
    m_signal = 0;
    m_error  = 0;
    exp_q.delete();
    repeat (5) @(posedge clk);
    #1 reset = 1'b1;
  endtask

  // mode 0 random, 1 all SYM_P3, 2 alternating SYM_M3 and SYM_P3
  task automatic make_symbols(input int blocks, input int mode, input bit gaps);
    symbol_e s;
    sym_q.delete();
    gap_q.delete();
    for (int i = 0; i < blocks * BLOCK; i++)
    begin
      case (mode)
        0:       s = symbol_e'(2'($random(seed)));
        1:       s = SYM_P3;
        default: s = ((i % 2) != 0) ? SYM_P3 : SYM_M3;
      endcase
      sym_q.push_back(s);
      gap_q.push_back(gaps ? ($random(seed) & 3) : 0);
    end
  endtask

  task automatic drive_symbols();
    int waited;
    bit taken;
    foreach (sym_q[i])
    begin
      if (gap_q[i] > 0)
      begin
        sym_valid = 1'b0;
        repeat (gap_q[i])
        begin
          @(posedge clk);
          #1;
        end
      end
      sym_valid = 1'b1;
      sym       = sym_q[i];
      waited    = 0;
      taken     = 1'b0;
      while (!taken)
      begin
        @(negedge clk);
        taken = sym_ready;             // transfer happens on the next edge
        waited++;
        if (!taken && waited > 500)
          hard_error("timeout, sym_ready stayed low");
        @(posedge clk);
        #1;
      end
      model_symbol(sym_q[i]);
    end
    sym_valid = 1'b0;
  endtask

  task automatic collect_reports(input int count, input bit stall);
    int          waited;
    int          hold;
    bit          done;
    mer_report_t expected;
    for (int n = 0; n < count; n++)
    begin
      hold   = stall ? 3 + ($random(seed) & 7) : 0;  // cycles to sit on a report
      waited = 0;
      done   = 1'b0;
      while (!done)
      begin
        @(negedge clk);
        if (report_valid && report_ready)
        begin
          if (exp_q.size() == 0)
            hard_error("a report arrived with no block expected");
          expected = exp_q.pop_front();
          compare_report(report, expected, n);
          got_q.push_back(report);
          done = 1'b1;
        end
        else if (report_valid && hold > 0)
          hold--;
        waited++;
        if (waited > 5000)
          hard_error("timeout waiting for a block report");
        @(posedge clk);
        #1;
        report_ready = !stall || (report_valid && hold == 0);
      end
      report_ready = !stall;
    end
  endtask

  task automatic run_phase(input string name, input bit stall);
    int blocks;
    blocks = sym_q.size() / BLOCK;
    got_q.delete();
    report_ready = !stall;
    fork
      drive_symbols();
      collect_reports(blocks, stall);
    join
    repeat (8)
    begin
      @(negedge clk);
      if (report_valid)
        hard_error({name, ": an extra report appeared"});
    end
    compare_count(got_q.size(), blocks, {name, " reports"});
    compare_count(exp_q.size(), 0, {name, " blocks left unreported"});
  endtask

  //************************************************************
  // test sequence
  //************************************************************

  initial
  begin
    seed         = 21709;
    reset        = 1'b0;
    sym_valid    = 1'b0;
    sym          = SYM_M3;
    report_ready = 1'b0;
    saw_full     = 1'b0;

    // steady traffic from zeroed taps, first block holds partial ISI
    apply_reset();
    make_symbols(8, 0, 1);
    saved_gaps = gap_q;
    foreach (gap_q[i])
      gap_q[i] = 0;
    run_phase("steady", 1'b0);
    first_pass = got_q;

    // same symbols with idle gaps must give the same reports
    apply_reset();
    gap_q = saved_gaps;
    run_phase("gapped", 1'b0);
    foreach (got_q[i])
      compare_report(got_q[i], first_pass[i], i);

    // report stalls push back through the whole chain
    apply_reset();
    make_symbols(6, 0, 0);
    saw_full = 1'b0;
    run_phase("stalled", 1'b1);
    if (!saw_full)
      hard_error("sym_ready never dropped while a report was held");

    // constant ISI, no symbol may be lost
    apply_reset();
    make_symbols(2, 1, 0);
    run_phase("all P3", 1'b0);
    foreach (got_q[i])
      compare_count(int'(got_q[i].symbol_errors), 0, "all P3 symbol_errors");

    // slicer thresholds under worst case outer taps
    apply_reset();
    make_symbols(2, 2, 0);
    run_phase("alternating", 1'b0);

    if (uut.u_asserts.fail_count != 0)
    begin
      $display("ERROR: %0d assertion failures", uut.u_asserts.fail_count);
      $display(">>> FAIL");
      $fatal(1, "assertion failures");
    end
    else
    begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bench/mer_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module mer_asserts
  import mer_pkg::*;
(
  input wire              clk,
  input wire              reset,          // active low
  input wire              sym_ready,
  input wire              map_valid,
  input wire              map_ready,
  input wire              ch_valid,
  input wire              ch_ready,
  input wire              report_valid,
  input wire              report_ready,
  input wire mer_report_t report
);

  int unsigned fail_count = 0;            // read by the testbench at the end

  //************************************************************
  // reset state, sampled mid-cycle
  //************************************************************

  reset_state: assert property (@(negedge clk)
    !reset |-> !map_valid && !ch_valid && !report_valid && sym_ready && map_ready && ch_ready)
    else
    begin
      fail_count++;
      $error("valid high or ready low during reset");
    end

  //************************************************************
  // handshakes
  //************************************************************

  report_hold: assert property (@(posedge clk) disable iff (!reset)
    report_valid && !report_ready |=> report_valid && $stable(report))
    else
    begin
      fail_count++;
      $error("report changed or dropped before transfer");
    end

  // input stalls only once every stage holds data, report included
  full_only: assert property (@(posedge clk) disable iff (!reset)
    !sym_ready |-> map_valid && ch_valid && report_valid)
    else
    begin
      fail_count++;
      $error("sym_ready low with room left in the pipeline");
    end

endmodule

bind mer_test_top mer_asserts u_asserts (
  .clk          (clk),
  .reset        (reset),
  .sym_ready    (sym_ready),
  .map_valid    (map_valid),
  .map_ready    (map_ready),
  .ch_valid     (ch_valid),
  .ch_ready     (ch_ready),
  .report_valid (report_valid),
  .report_ready (report_ready),
  .report       (report)
);

`default_nettype wire

/* source/mer_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mer_test_top
  import mer_pkg::*;
(
  input  wire          clk,
  input  wire          reset,         // active low
  input  wire          sym_valid,
  input  wire symbol_e sym,
  output logic         sym_ready,
  output logic         report_valid,
  output mer_report_t  report,
  input  wire          report_ready
);

  //************************************************************
  // inter-block links
  //************************************************************

  logic         map_valid;
  logic         map_ready;
  sample_t      map_sample;   // mapper to channel
  logic         ch_valid;
  logic         ch_ready;
  channel_out_t ch_result;    // channel to accumulator

  symbol_mapper u_mapper (
    .clk        (clk),
    .reset      (reset),
    .sym_valid  (sym_valid),
    .sym        (sym),
    .sym_ready  (sym_ready),
    .map_valid  (map_valid),
    .map_sample (map_sample),
    .map_ready  (map_ready)
  );

  isi_channel u_channel (
    .clk        (clk),
    .reset      (reset),
    .map_valid  (map_valid),
    .map_sample (map_sample),
    .map_ready  (map_ready),
    .ch_valid   (ch_valid),
    .ch_result  (ch_result),
    .ch_ready   (ch_ready)
  );

  mer_accumulator u_accum (
    .clk          (clk),
    .reset        (reset),
    .ch_valid     (ch_valid),
    .ch_result    (ch_result),
    .ch_ready     (ch_ready),
    .report_valid (report_valid),
    .report       (report),
    .report_ready (report_ready)
  );

endmodule

`default_nettype wire

/* source/mer_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mer_macros.svh"

module mer_accumulator
  import mer_pkg::*;
(
  input  wire               clk,
  input  wire               reset,         // active low
  input  wire               ch_valid,
  input  wire channel_out_t ch_result,
  output logic              ch_ready,
  output logic              report_valid,
  output mer_report_t       report,
  input  wire               report_ready
);

  localparam int W     = `MER_DATA_WIDTH;
  localparam int ACC_W = `MER_ACC_WIDTH;
  localparam int GAIN  = `MER_CHANNEL_GAIN;
  localparam int CNT_W = $clog2(`MER_BLOCK_LEN);

  // decision thresholds at +-1/2 full scale, scaled by the channel gain
  localparam logic signed [W-1:0] TH_HI = W'((1 << (W - 2)) >>> GAIN);
  localparam logic signed [W-1:0] TH_LO = -TH_HI;

  //************************************************************
  // declarations
  //************************************************************

  acc_state_e          state;
  logic [CNT_W-1:0]    sym_count;   // symbols taken in this block
  mer_report_t         acc;         // running block totals
  symbol_e             dec_sym;     // slice of decision
  symbol_e             ref_sym;     // slice of errorless
  logic signed [W-1:0] ideal;       // nominal level of dec_sym after gain
  logic signed [W:0]   miss;        // decision minus ideal
  logic signed [2*W-1:0] sig_sq;
  logic signed [2*W+1:0] err_sq;
  logic                sym_err;
  logic                take;

  // nearest scaled level, ties go to the upper level
  function automatic symbol_e slice(input logic signed [W-1:0] x);
    symbol_e s;
    if (x >= TH_HI)
      s = SYM_P3;
    else if (x >= 0)
      s = SYM_P1;
    else if (x >= TH_LO)
      s = SYM_M1;
    else
      s = SYM_M3;
    return s;
  endfunction

  //************************************************************
  // handshake
  //************************************************************

  assign ch_ready     = (state == ACC_RUN);     // no intake while holding a report
  assign report_valid = (state == ACC_REPORT);
  assign report       = acc;                    // totals frozen in ACC_REPORT
  assign take         = ch_valid && ch_ready;

  //************************************************************
  // slicer and energies
  //************************************************************

  always_comb
  begin
    dec_sym = slice(ch_result.decision);
    ref_sym = slice(ch_result.errorless);
    sym_err = (dec_sym != ref_sym);
    ideal   = symbol_level(dec_sym) >>> GAIN;
    miss    = ch_result.decision - ideal;        // 19 bits, sign extended
    sig_sq  = ideal * ideal;                     // never negative
    err_sq  = miss * miss;
  end

  //************************************************************
  // block control
  //************************************************************

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      state     <= ACC_RUN;
      sym_count <= '0;
      acc       <= '0;
    end
    else
    begin
      case (state)
        ACC_RUN:
        begin
          if (take)
          begin
            acc.symbol_errors <= acc.symbol_errors + 16'(sym_err);
            acc.signal_energy <= acc.signal_energy + ACC_W'(sig_sq);
            acc.error_energy  <= acc.error_energy + ACC_W'(err_sq);
            if (sym_count == CNT_W'(`MER_BLOCK_LEN - 1))
            begin
              sym_count <= '0;
              state     <= ACC_REPORT;    // last symbol of the block
            end
            else
            begin
              sym_count <= sym_count + 1'b1;
            end
          end
        end
        ACC_REPORT:
        begin
          if (report_ready)
          begin
            acc   <= '0;                  // fresh block after handoff
            state <= ACC_RUN;
          end
        end
        default:
        begin
          state <= ACC_RUN;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/isi_channel.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mer_macros.svh"

module isi_channel
  import mer_pkg::*;
(
  input  wire          clk,
  input  wire          reset,      // active low
  input  wire          map_valid,
  input  wire sample_t map_sample,
  output logic         map_ready,
  output logic         ch_valid,
  output channel_out_t ch_result,
  input  wire          ch_ready
);

  localparam int W    = `MER_DATA_WIDTH;
  localparam int GAIN = `MER_CHANNEL_GAIN;

  localparam logic signed [W-1:0] ISI_POWER = W'(`MER_ISI_POWER);  // 1s17 coefficient

  //************************************************************
  // declarations
  //************************************************************

  logic signed [W-1:0]   hist [2];     // two previous accepted levels
  logic signed [W-1:0]   taps [3];     // delay line as seen after the shift
  logic signed [W:0]     outer_sum;    // 2s17, room for worst case outer taps
  logic signed [2*W:0]   isi_full;     // 2s17 * 1s17 = 3s34
  logic signed [W-1:0]   isi_term;     // back to 1s17
  logic signed [W-1:0]   err_next;
  logic signed [W-1:0]   errless_next;
  logic                  take;         // sample transfer on this edge

  //************************************************************
  // handshake
  //************************************************************

  assign map_ready = !ch_valid || ch_ready;
  assign take      = map_valid && map_ready;

  //************************************************************
  // delay line
  //************************************************************

  // newest tap is the incoming sample, so the result register
  // is loaded from the taps as they stand after this shift
  always_comb
  begin
    taps[0] = map_sample.level;
    taps[1] = hist[0];          // centre tap
    taps[2] = hist[1];
  end

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      hist[0] <= '0;  // first results carry partial ISI
      hist[1] <= '0;
    end
    else if (take)
    begin
      hist[0] <= taps[0];
      hist[1] <= taps[1];
    end
  end

  //************************************************************
  // ISI term and gain
  //************************************************************

  always_comb
  begin
    outer_sum    = taps[0] + taps[2];            // sign extended to 19 bits
    isi_full     = outer_sum * ISI_POWER;
    isi_term     = isi_full[2*W-2:W-1];          // bits 34..17
    err_next     = isi_term >>> GAIN;            // gain is a right shift
    errless_next = taps[1] >>> GAIN;
  end

  //************************************************************
  // result register
  //************************************************************

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      ch_valid <= 1'b0;
    end
    else if (map_ready)
    begin
      ch_valid <= map_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      ch_result.error     <= err_next;
      ch_result.errorless <= errless_next;
      ch_result.decision  <= err_next + errless_next;  // no headroom issue at these levels
    end
  end

endmodule

`default_nettype wire

/* source/symbol_mapper.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mer_macros.svh"

module symbol_mapper
  import mer_pkg::*;
(
  input  wire        clk,
  input  wire        reset,       // active low
  input  wire        sym_valid,
  input  wire symbol_e sym,
  output logic       sym_ready,
  output logic       map_valid,
  output sample_t    map_sample,
  input  wire        map_ready
);

  //************************************************************
  // declarations
  //************************************************************

  logic signed [`MER_DATA_WIDTH-1:0] level;  // Q1.17 level of incoming symbol
  logic                              take;   // symbol transfer on this edge

  //************************************************************
  // handshake
  //************************************************************

  assign sym_ready = !map_valid || map_ready;  // register empty or draining
  assign take      = sym_valid && sym_ready;

  assign level = symbol_level(sym);  // enum to level lookup

  //************************************************************
  // output register
  //************************************************************

  always_ff @(posedge clk or negedge reset)
  begin
    if (!reset)
    begin
      map_valid <= 1'b0;
    end
    else if (sym_ready)
    begin
      map_valid <= sym_valid;  // refill or empty when downstream takes
    end
  end

  // payload only moves on a transfer, so it holds while stalled
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      map_sample.level <= level;
      map_sample.sym   <= sym;   // enum travels along for the slicer check
    end
  end

endmodule

`default_nettype wire

/* source/mer_pkg.sv */
`default_nettype none
`include "mer_macros.svh"

package mer_pkg;

  // quarter of full scale in Q1.17
  localparam int LVL_QUARTER = 1 << (`MER_DATA_WIDTH - 3);

  // 4-ASK symbols, ordered from most negative level upward
  typedef enum logic [1:0] {
    SYM_M3 = 2'd0,  // -3/4 full scale
    SYM_M1 = 2'd1,  // -1/4
    SYM_P1 = 2'd2,  // +1/4
    SYM_P3 = 2'd3   // +3/4
  } symbol_e;

  typedef struct packed {
    logic signed [`MER_DATA_WIDTH-1:0] level;  // Q1.17 level
    symbol_e                           sym;    // symbol it came from
  } sample_t;

  typedef struct packed {
    logic signed [`MER_DATA_WIDTH-1:0] decision;   // errorless plus error
    logic signed [`MER_DATA_WIDTH-1:0] errorless;  // centre tap after gain
    logic signed [`MER_DATA_WIDTH-1:0] error;      // ISI term after gain
  } channel_out_t;

  typedef struct packed {
    logic [15:0]               symbol_errors;
    logic [`MER_ACC_WIDTH-1:0] signal_energy;  // sum of ideal level squared
    logic [`MER_ACC_WIDTH-1:0] error_energy;   // sum of miss squared
  } mer_report_t;

  typedef enum logic {
    ACC_RUN,     // collecting a block
    ACC_REPORT   // holding the block report
  } acc_state_e;

  // nominal full-scale level of a symbol, before any channel gain
  function automatic logic signed [`MER_DATA_WIDTH-1:0] symbol_level(input symbol_e s);
    logic signed [`MER_DATA_WIDTH-1:0] lvl;
    case (s)
      SYM_M3:  lvl = `MER_DATA_WIDTH'(-3 * LVL_QUARTER);
      SYM_M1:  lvl = `MER_DATA_WIDTH'(-LVL_QUARTER);
      SYM_P1:  lvl = `MER_DATA_WIDTH'(LVL_QUARTER);
      default: lvl = `MER_DATA_WIDTH'(3 * LVL_QUARTER);
    endcase
    return lvl;
  endfunction

endpackage

`default_nettype wire

/* source/mer_macros.svh */
`ifndef MER_MACROS_SVH
`define MER_MACROS_SVH

//************************************************************
// sample format
//************************************************************

// signed Q1.17 samples throughout the chain
`define MER_DATA_WIDTH 18

//************************************************************
// channel model
//************************************************************

// ISI coefficient in Q1.17, about 0.1257 of full scale
// gives roughly 15 dB MER before the gain is applied
`define MER_ISI_POWER 16481

// channel gain is 2**(-MER_CHANNEL_GAIN), integer shift only
`define MER_CHANNEL_GAIN 1

//************************************************************
// measurement block
//************************************************************

`define MER_BLOCK_LEN 64   // symbols per report
`define MER_ACC_WIDTH 48   // energy accumulator width

`endif
